// ==== files.f ====
verilog/lpif_pkg.sv
verilog/lpif_auto_sync.sv
verilog/lpif_user_if.sv
verilog/lpif_lane_concat.sv
verilog/lpif_link_top.sv
test/tb_clock_gen.sv
test/lpif_link_tb.sv

// ==== Makefile ====
# Verilator build and run for the LPIF link shim
# Exit status of the simulation binary is the test result

VERILATOR ?= verilator
TOP       ?= lpif_link_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables (override on the command line):"
	@echo "  VERILATOR=$(VERILATOR) TOP=$(TOP) FILELIST=$(FILELIST)"
	@echo "  BUILD_DIR=$(BUILD_DIR) JOBS=$(JOBS) VFLAGS='$(VFLAGS)'"

test:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

// ==== test/lpif_link_tb.sv ====
// Loopback testbench for the LPIF link shim
// tx_phy lanes feed rx_phy through wires, lane 0 strobe can be cleared
// Expected values come from a timing model of the online delays
// tx_online and rx_online each go up and down once, no toggling in drain

`timescale 1ns/10ps
`default_nettype none

module lpif_link_tb import lpif_pkg::*; ();

  localparam int DELAY_WIDTH = 16;
  localparam int DLY_X       = 5;
  localparam int DLY_Y       = 7;
  localparam int DLY_Z       = 4;
  // Upper bound on the stimulus length in cycles
  localparam int STIM_CYCLES = 1000;

  logic                    clk_wr;
  logic                    rst_n;
  logic                    tx_online;
  logic                    rx_online;
  logic [DELAY_WIDTH-1:0]  delay_x_value;
  logic [DELAY_WIDTH-1:0]  delay_y_value;
  logic [DELAY_WIDTH-1:0]  delay_z_value;
  logic [LANE_WIDTH-1:0]   tx_phy0;
  logic [LANE_WIDTH-1:0]   tx_phy1;
  logic [LANE_WIDTH-1:0]   tx_phy2;
  logic [LANE_WIDTH-1:0]   rx_phy0;
  logic [LANE_WIDTH-1:0]   rx_phy1;
  logic [LANE_WIDTH-1:0]   rx_phy2;
  logic [STATE_WIDTH-1:0]  dstrm_state;
  logic [PROTID_WIDTH-1:0] dstrm_protid;
  logic [DATA_WIDTH-1:0]   dstrm_data;
  logic                    dstrm_dvalid;
  logic [CRC_WIDTH-1:0]    dstrm_crc;
  logic                    dstrm_crc_valid;
  logic                    dstrm_valid;
  logic [STATE_WIDTH-1:0]  ustrm_state;
  logic [PROTID_WIDTH-1:0] ustrm_protid;
  logic [DATA_WIDTH-1:0]   ustrm_data;
  logic                    ustrm_dvalid;
  logic [CRC_WIDTH-1:0]    ustrm_crc;
  logic                    ustrm_crc_valid;
  logic                    ustrm_valid;
  logic [31:0]             rx_debug_status;

  // Timing model and scoreboard
  logic       corrupt    = 1'b0;
  int         tx_on_cnt  = 0;
  int         tx_off_cnt = 0;
  int         rx_on_cnt  = 0;
  logic       tx_act_m   = 1'b0;
  logic       rx_act_m   = 1'b0;
  logic       lane_stb_m = 1'b0;
  logic [31:0] exp_drops = '0;
  lpif_word_t exp_word   = '0;
  lpif_word_t sent_q[$];
  int         rcv_cnt    = 0;
  int         cyc        = 0;
  integer     seed;

  tb_clock_gen #(
    .PERIOD_NS    (100),
    .RESET_CYCLES (3)
  ) i_tb_clock_gen (
    .clk_wr (clk_wr),
    .rst_n  (rst_n)
  );

  lpif_link_top #(
    .DELAY_WIDTH (DELAY_WIDTH)
  ) i_lpif_link_top (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .tx_phy0         (tx_phy0),
    .tx_phy1         (tx_phy1),
    .tx_phy2         (tx_phy2),
    .rx_phy0         (rx_phy0),
    .rx_phy1         (rx_phy1),
    .rx_phy2         (rx_phy2),
    .dstrm_state     (dstrm_state),
    .dstrm_protid    (dstrm_protid),
    .dstrm_data      (dstrm_data),
    .dstrm_dvalid    (dstrm_dvalid),
    .dstrm_crc       (dstrm_crc),
    .dstrm_crc_valid (dstrm_crc_valid),
    .dstrm_valid     (dstrm_valid),
    .ustrm_state     (ustrm_state),
    .ustrm_protid    (ustrm_protid),
    .ustrm_data      (ustrm_data),
    .ustrm_dvalid    (ustrm_dvalid),
    .ustrm_crc       (ustrm_crc),
    .ustrm_crc_valid (ustrm_crc_valid),
    .ustrm_valid     (ustrm_valid),
    .rx_debug_status (rx_debug_status),
    .delay_x_value   (delay_x_value),
    .delay_y_value   (delay_y_value),
    .delay_z_value   (delay_z_value)
  );

  // External loopback, strobe cleared while corrupt is set
  assign rx_phy0 = tx_phy0 & ~(LANE_WIDTH'(corrupt) << STB_BIT);
  assign rx_phy1 = tx_phy1;
  assign rx_phy2 = tx_phy2;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string msg);
    abort_run($sformatf("[FAIL] %0t: %s", $time, msg));
  endtask

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  always @(posedge clk_wr) begin
    cyc <= cyc + 1;
  end

  always @(posedge clk_wr) begin
    lpif_word_t w;
    w.state     = dstrm_state;
    w.protid    = dstrm_protid;
    w.data      = dstrm_data;
    w.dvalid    = dstrm_dvalid;
    w.crc       = dstrm_crc;
    w.crc_valid = dstrm_crc_valid;
    w.valid     = dstrm_valid;
    if (!rst_n) begin
      tx_on_cnt  <= 0;
      tx_off_cnt <= 0;
      rx_on_cnt  <= 0;
      tx_act_m   <= 1'b0;
      rx_act_m   <= 1'b0;
      lane_stb_m <= 1'b0;
      exp_drops  <= '0;
      exp_word   <= '0;
      sent_q.delete();
    end else begin
      tx_on_cnt  <= tx_online ? tx_on_cnt + 1 : 0;
      tx_off_cnt <= tx_online ? 0 : tx_off_cnt + 1;
      rx_on_cnt  <= rx_online ? rx_on_cnt + 1 : 0;
      // Up after DLY_Y high samples, down after DLY_Z low samples
      if (!tx_act_m) begin
        tx_act_m <= tx_online && (tx_on_cnt + 1 >= DLY_Y);
      end else begin
        tx_act_m <= tx_online || (tx_off_cnt + 1 < DLY_Z);
      end
      rx_act_m   <= rx_online && (rx_on_cnt + 1 >= DLY_X);
      // Strobe reaches the lanes one cycle after tx goes active
      lane_stb_m <= tx_act_m;
      // Every cycle without a strobe on an active rx side is a drop
      exp_drops  <= exp_drops + 32'(rx_act_m && !(lane_stb_m && !corrupt));
      // Four cycle loopback
      sent_q.push_back(w);
      if (sent_q.size() == 4) begin
        exp_word <= sent_q.pop_front();
      end
      if (ustrm_valid) begin
        rcv_cnt <= rcv_cnt + 1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  a_reset_zero: assert property (@(posedge clk_wr)
    (cyc >= 1 && !$past(rst_n)) |-> (tx_phy0 == '0 && tx_phy1 == '0 && tx_phy2 == '0
      && !ustrm_valid && !ustrm_dvalid && !ustrm_crc_valid && rx_debug_status == '0))
    else report_mismatch("outputs not zero after reset");

  a_lanes_idle: assert property (@(posedge clk_wr) disable iff (!rst_n)
    !$past(tx_act_m) |-> (tx_phy0 == '0 && tx_phy1 == '0 && tx_phy2 == '0))
    else report_mismatch("lanes not zero while tx side is down");

  // Rise after DLY_Y, fall after DLY_Z
  a_strobe_timing: assert property (@(posedge clk_wr) disable iff (!rst_n)
    tx_phy0[STB_BIT] == $past(tx_act_m))
    else report_mismatch("lane 0 strobe edge at the wrong cycle");

  // Marker follows the strobe, lane 2 bits above the payload stay zero
  a_marker_timing: assert property (@(posedge clk_wr) disable iff (!rst_n)
    tx_phy1[MRK_BIT] == $past(tx_act_m)
      && tx_phy2[LANE_WIDTH-1:LANE2_PAYLOAD] == '0)
    else report_mismatch("lane 1 marker or unused lane 2 bits wrong");

  a_valid_match: assert property (@(posedge clk_wr) disable iff (!rst_n)
    ustrm_valid == (exp_word.valid && $past(tx_act_m, 3) && $past(rx_act_m, 2)
      && !$past(corrupt, 2)))
    else report_mismatch("ustrm_valid differs from expected");

  a_fields_match: assert property (@(posedge clk_wr) disable iff (!rst_n)
    ustrm_valid |-> (ustrm_state == exp_word.state && ustrm_protid == exp_word.protid
      && ustrm_data == exp_word.data && ustrm_dvalid == exp_word.dvalid
      && ustrm_crc == exp_word.crc && ustrm_crc_valid == exp_word.crc_valid))
    else report_mismatch("ustrm fields differ from the sent word");

  a_qual_in_valid: assert property (@(posedge clk_wr) disable iff (!rst_n)
    (ustrm_dvalid || ustrm_crc_valid) |-> ustrm_valid)
    else report_mismatch("ustrm qualifier set outside a valid word");

  a_state_hold: assert property (@(posedge clk_wr) disable iff (!rst_n)
    !ustrm_valid |-> $stable(ustrm_state))
    else report_mismatch("ustrm_state moved on an invalid word");

  a_drop_count: assert property (@(posedge clk_wr) disable iff (!rst_n)
    rx_debug_status == exp_drops)
    else report_mismatch("rx_debug_status differs from expected drop count");

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  task automatic send_words(input int n, input logic with_corrupt);
    logic [31:0] r;
    logic        v;
    repeat (n) begin
      @(posedge clk_wr);
      r = $random(seed);
      v = r[0] | r[1];
      dstrm_valid     <= v;
      dstrm_dvalid    <= v & r[2];
      dstrm_crc_valid <= v & r[3];
      dstrm_state     <= r[7:4];
      dstrm_protid    <= r[9:8];
      dstrm_crc       <= r[31:16];
      dstrm_data      <= {$random(seed), $random(seed)};
      // About one corrupted strobe in eight
      corrupt         <= with_corrupt && (r[12:10] == 3'd0);
    end
  endtask

  initial begin
    seed            = 32'hf856633d;
    tx_online       = 1'b0;
    rx_online       = 1'b0;
    delay_x_value   = DELAY_WIDTH'(DLY_X);
    delay_y_value   = DELAY_WIDTH'(DLY_Y);
    delay_z_value   = DELAY_WIDTH'(DLY_Z);
    dstrm_state     = '0;
    dstrm_protid    = '0;
    dstrm_data      = '0;
    dstrm_dvalid    = 1'b0;
    dstrm_crc       = '0;
    dstrm_crc_valid = 1'b0;
    dstrm_valid     = 1'b0;
    while (rst_n !== 1'b1) @(posedge clk_wr);
    // Both sides down
    send_words(10, 1'b0);
    tx_online <= 1'b1;
    // Lanes carry words, rx side still down
    send_words(DLY_Y + 20, 1'b0);
    rx_online <= 1'b1;
    send_words(300, 1'b0);
    send_words(300, 1'b1);
    send_words(100, 1'b0);
    rx_online <= 1'b0;
    send_words(20, 1'b0);
    tx_online <= 1'b0;
    send_words(DLY_Z + 20, 1'b0);
    if (rcv_cnt == 0 || exp_drops == '0) begin
      abort_run("End of test reached without looped-back words or without drops");
    end else begin
      $display("sim passed");
      $finish;
    end
  end

  // Watchdog at twice the stimulus bound
  initial begin
    repeat (2 * STIM_CYCLES) @(posedge clk_wr);
    abort_run($sformatf("Timeout: stimulus still running after %0d cycles", 2 * STIM_CYCLES));
  end

endmodule

`default_nettype wire

// ==== test/tb_clock_gen.sv ====
// Clock and reset source for the link testbench
// Reset is low for RESET_CYCLES rising edges, then released on an edge

`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 3
) (
  output logic clk_wr,
  output logic rst_n
);

  // Free running clock, first rising edge at half a period
  initial begin
    clk_wr = 1'b0;
    forever #(PERIOD_NS / 2) clk_wr = ~clk_wr;
  end

  // Release on an edge so DUT and model see the same cycle
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_wr);
    rst_n <= 1'b1;
  end

endmodule

`default_nettype wire

// ==== verilog/lpif_link_top.sv ====
// Top level of the LPIF link shim, single clock
// Downstream sample to tx_phy takes 2 cycles
// rx_phy sample to upstream ports takes 2 cycles
// Full rate only, no FIFO or credit logic, no lane deskew

`timescale 1ns/10ps
`default_nettype none

module lpif_link_top import lpif_pkg::*; #(
  parameter int DELAY_WIDTH = 16
) (
  input  logic                    clk_wr,
  input  logic                    rst_n,

  // Control
  input  logic                    tx_online,
  input  logic                    rx_online,

  // PHY lanes
  output logic [LANE_WIDTH-1:0]   tx_phy0,
  output logic [LANE_WIDTH-1:0]   tx_phy1,
  output logic [LANE_WIDTH-1:0]   tx_phy2,
  input  logic [LANE_WIDTH-1:0]   rx_phy0,
  input  logic [LANE_WIDTH-1:0]   rx_phy1,
  input  logic [LANE_WIDTH-1:0]   rx_phy2,

  // Downstream user fields
  input  logic [STATE_WIDTH-1:0]  dstrm_state,
  input  logic [PROTID_WIDTH-1:0] dstrm_protid,
  input  logic [DATA_WIDTH-1:0]   dstrm_data,
  input  logic                    dstrm_dvalid,
  input  logic [CRC_WIDTH-1:0]    dstrm_crc,
  input  logic                    dstrm_crc_valid,
  input  logic                    dstrm_valid,

  // Upstream user fields
  output logic [STATE_WIDTH-1:0]  ustrm_state,
  output logic [PROTID_WIDTH-1:0] ustrm_protid,
  output logic [DATA_WIDTH-1:0]   ustrm_data,
  output logic                    ustrm_dvalid,
  output logic [CRC_WIDTH-1:0]    ustrm_crc,
  output logic                    ustrm_crc_valid,
  output logic                    ustrm_valid,

  // Status and configuration
  output logic [31:0]             rx_debug_status,
  input  logic [DELAY_WIDTH-1:0]  delay_x_value,
  input  logic [DELAY_WIDTH-1:0]  delay_y_value,
  input  logic [DELAY_WIDTH-1:0]  delay_z_value
);

  lpif_word_t tx_word;
  lpif_word_t rx_word;
  logic       tx_active;
  logic       tx_stb;
  logic       tx_mrk;
  logic       rx_active;

  //////////////////////////////////////////////////
  // Online delays and lane control bits
  lpif_auto_sync #(
    .DELAY_WIDTH (DELAY_WIDTH)
  ) i_lpif_auto_sync (
    .clk_wr        (clk_wr),
    .rst_n         (rst_n),
    .tx_online     (tx_online),
    .rx_online     (rx_online),
    .delay_x_value (delay_x_value),
    .delay_y_value (delay_y_value),
    .delay_z_value (delay_z_value),
    .tx_active     (tx_active),
    .tx_stb        (tx_stb),
    .tx_mrk        (tx_mrk),
    .rx_active     (rx_active)
  );

  // Field packing and unpacking
  lpif_user_if i_lpif_user_if (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .dstrm_state     (dstrm_state),
    .dstrm_protid    (dstrm_protid),
    .dstrm_data      (dstrm_data),
    .dstrm_dvalid    (dstrm_dvalid),
    .dstrm_crc       (dstrm_crc),
    .dstrm_crc_valid (dstrm_crc_valid),
    .dstrm_valid     (dstrm_valid),
    .tx_word         (tx_word),
    .rx_word         (rx_word),
    .ustrm_state     (ustrm_state),
    .ustrm_protid    (ustrm_protid),
    .ustrm_data      (ustrm_data),
    .ustrm_dvalid    (ustrm_dvalid),
    .ustrm_crc       (ustrm_crc),
    .ustrm_crc_valid (ustrm_crc_valid),
    .ustrm_valid     (ustrm_valid)
  );

  // Lane spread, gather and strobe check
  lpif_lane_concat i_lpif_lane_concat (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .tx_word         (tx_word),
    .rx_word         (rx_word),
    .tx_active       (tx_active),
    .tx_stb          (tx_stb),
    .tx_mrk          (tx_mrk),
    .rx_active       (rx_active),
    .tx_phy0         (tx_phy0),
    .tx_phy1         (tx_phy1),
    .tx_phy2         (tx_phy2),
    .rx_phy0         (rx_phy0),
    .rx_phy1         (rx_phy1),
    .rx_phy2         (rx_phy2),
    .rx_debug_status (rx_debug_status)
  );

endmodule

`default_nettype wire

// ==== verilog/lpif_lane_concat.sv ====
// Lane concatenator for the link shim
// Spreads one 89-bit word over three 40-bit lanes, one cycle of latency
// Lanes are all zero while tx_active is low
// Receive side rebuilds the word one cycle after sampling the lanes
// Missing strobe while rx_active drops the word and bumps a saturating counter
// Marker and unused lane 2 bits are not checked on receive

`timescale 1ns/10ps
`default_nettype none

module lpif_lane_concat import lpif_pkg::*; (
  input  logic                  clk_wr,
  input  logic                  rst_n,

  // Link words
  input  lpif_word_t            tx_word,
  output lpif_word_t            rx_word,

  // Auto-sync controls
  input  logic                  tx_active,
  input  logic                  tx_stb,
  input  logic                  tx_mrk,
  input  logic                  rx_active,

  // PHY lanes
  output logic [LANE_WIDTH-1:0] tx_phy0,
  output logic [LANE_WIDTH-1:0] tx_phy1,
  output logic [LANE_WIDTH-1:0] tx_phy2,
  input  logic [LANE_WIDTH-1:0] rx_phy0,
  input  logic [LANE_WIDTH-1:0] rx_phy1,
  input  logic [LANE_WIDTH-1:0] rx_phy2,

  output logic [31:0]           rx_debug_status
);

  logic [WORD_WIDTH-1:0] tx_flat;
  logic [LANE_WIDTH-1:0] lane0_nxt;
  logic [LANE_WIDTH-1:0] lane1_nxt;
  logic [LANE_WIDTH-1:0] lane2_nxt;
  lpif_word_t            rx_raw;
  logic                  rx_stb_ok;
  logic                  rx_drop;
  logic [31:0]           drop_cnt;

  //////////////////////////////////////////////////
  // Transmit lanes
  //////////////////////////////////////////////////

  assign tx_flat = tx_word;

  always_comb begin
    lane0_nxt = '0;
    lane1_nxt = '0;
    lane2_nxt = '0;
    // Low word bits first, lane 0 upward
    lane0_nxt[LANE_PAYLOAD-1:0]  = tx_flat[LANE_PAYLOAD-1:0];
    lane1_nxt[LANE_PAYLOAD-1:0]  = tx_flat[2*LANE_PAYLOAD-1:LANE_PAYLOAD];
    lane2_nxt[LANE2_PAYLOAD-1:0] = tx_flat[WORD_WIDTH-1:2*LANE_PAYLOAD];
    // Control bits on top of lanes 0 and 1
    lane0_nxt[STB_BIT] = tx_stb;
    lane1_nxt[MRK_BIT] = tx_mrk;
  end

  always_ff @(posedge clk_wr) begin
    if (!rst_n || !tx_active) begin
      tx_phy0 <= '0;
      tx_phy1 <= '0;
      tx_phy2 <= '0;
    end else begin
      tx_phy0 <= lane0_nxt;
      tx_phy1 <= lane1_nxt;
      tx_phy2 <= lane2_nxt;
    end
  end

  //////////////////////////////////////////////////
  // Receive lanes
  //////////////////////////////////////////////////

  // Rebuild in the same order as transmit
  assign rx_raw = {rx_phy2[LANE2_PAYLOAD-1:0],
                   rx_phy1[LANE_PAYLOAD-1:0],
                   rx_phy0[LANE_PAYLOAD-1:0]};

  assign rx_stb_ok = rx_phy0[STB_BIT];
  assign rx_drop   = rx_active & ~rx_stb_ok;

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      rx_word.valid <= 1'b0;
    end else begin
      rx_word       <= rx_raw;
      // Good word needs rx side up and a strobe
      rx_word.valid <= rx_raw.valid & rx_active & rx_stb_ok;
    end
  end

  // Drop counter, sticks at all ones
  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      drop_cnt <= '0;
    end else if (rx_drop && (drop_cnt != '1)) begin
      drop_cnt <= drop_cnt + 32'd1;
    end
  end

  assign rx_debug_status = drop_cnt;

  // Only reset may lower the drop count
  a_drop_cnt_monotonic: assert property (@(posedge clk_wr) disable iff (!rst_n)
    $past(rst_n) |-> (drop_cnt >= $past(drop_cnt)))
    else $error("rx drop counter decreased");

endmodule

`default_nettype wire

// ==== verilog/lpif_user_if.sv ====
// User side of the link shim
// Downstream fields are packed into one link word, one cycle of latency
// Received words are unpacked to upstream ports, one cycle of latency
// No back-pressure, every valid word is taken in the cycle it appears
// ustrm_dvalid and ustrm_crc_valid are forced low outside valid words

`timescale 1ns/10ps
`default_nettype none

module lpif_user_if import lpif_pkg::*; (
  input  logic                    clk_wr,
  input  logic                    rst_n,

  // Downstream user fields
  input  logic [STATE_WIDTH-1:0]  dstrm_state,
  input  logic [PROTID_WIDTH-1:0] dstrm_protid,
  input  logic [DATA_WIDTH-1:0]   dstrm_data,
  input  logic                    dstrm_dvalid,
  input  logic [CRC_WIDTH-1:0]    dstrm_crc,
  input  logic                    dstrm_crc_valid,
  input  logic                    dstrm_valid,

  // Link words to and from the lane block
  output lpif_word_t              tx_word,
  input  lpif_word_t              rx_word,

  // Upstream user fields
  output logic [STATE_WIDTH-1:0]  ustrm_state,
  output logic [PROTID_WIDTH-1:0] ustrm_protid,
  output logic [DATA_WIDTH-1:0]   ustrm_data,
  output logic                    ustrm_dvalid,
  output logic [CRC_WIDTH-1:0]    ustrm_crc,
  output logic                    ustrm_crc_valid,
  output logic                    ustrm_valid
);

  //////////////////////////////////////////////////
  // Transmit packing
  //////////////////////////////////////////////////

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      // Only the qualifier bits need a known value
      tx_word.dvalid    <= 1'b0;
      tx_word.crc_valid <= 1'b0;
      tx_word.valid     <= 1'b0;
    end else begin
      tx_word.state     <= dstrm_state;
      tx_word.protid    <= dstrm_protid;
      tx_word.data      <= dstrm_data;
      tx_word.dvalid    <= dstrm_dvalid;
      tx_word.crc       <= dstrm_crc;
      tx_word.crc_valid <= dstrm_crc_valid;
      tx_word.valid     <= dstrm_valid;
    end
  end

  //////////////////////////////////////////////////
  // Receive unpacking
  //////////////////////////////////////////////////

  // Qualifiers and sticky state
  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      ustrm_valid     <= 1'b0;
      ustrm_dvalid    <= 1'b0;
      ustrm_crc_valid <= 1'b0;
      ustrm_state     <= '0;
    end else begin
      ustrm_valid     <= rx_word.valid;
      ustrm_dvalid    <= rx_word.valid & rx_word.dvalid;
      ustrm_crc_valid <= rx_word.valid & rx_word.crc_valid;
      // Link state only moves on a good word
      if (rx_word.valid) begin
        ustrm_state <= rx_word.state;
      end
    end
  end

  // Payload follows the lanes every cycle
  always_ff @(posedge clk_wr) begin
    ustrm_protid <= rx_word.protid;
    ustrm_data   <= rx_word.data;
    ustrm_crc    <= rx_word.crc;
  end

  //////////////////////////////////////////////////
  // Input protocol checks
  //////////////////////////////////////////////////

  // Data qualifier only inside a valid transfer
  a_dvalid_in_valid: assert property (@(posedge clk_wr) disable iff (!rst_n)
    dstrm_dvalid |-> dstrm_valid)
    else $error("dstrm_dvalid without dstrm_valid");

  // Same rule for the CRC qualifier
  a_crc_valid_in_valid: assert property (@(posedge clk_wr) disable iff (!rst_n)
    dstrm_crc_valid |-> dstrm_valid)
    else $error("dstrm_crc_valid without dstrm_valid");

endmodule

`default_nettype wire

// ==== verilog/lpif_auto_sync.sv ====
// Online delay and strobe/marker generation for the link shim
// tx_active rises delay_y cycles after tx_online rises
// tx_active falls delay_z cycles after tx_online falls
// rx_active rises delay_x cycles after rx_online rises
// A delay of 0 behaves like a delay of 1
// tx_online toggling during DRAIN is ignored until DRAIN ends
// Strobe and marker are persistent and follow tx_active

`timescale 1ns/10ps
`default_nettype none

module lpif_auto_sync import lpif_pkg::*; #(
  parameter int DELAY_WIDTH = 16
) (
  input  logic                   clk_wr,
  input  logic                   rst_n,
  input  logic                   tx_online,
  input  logic                   rx_online,
  input  logic [DELAY_WIDTH-1:0] delay_x_value,
  input  logic [DELAY_WIDTH-1:0] delay_y_value,
  input  logic [DELAY_WIDTH-1:0] delay_z_value,
  output logic                   tx_active,
  output logic                   tx_stb,
  output logic                   tx_mrk,
  output logic                   rx_active
);

  sync_state_t            state;
  sync_state_t            state_nxt;
  logic [DELAY_WIDTH-1:0] tx_cnt;
  logic [DELAY_WIDTH-1:0] tx_cnt_nxt;
  logic [DELAY_WIDTH:0]   tx_cnt_inc;
  logic [DELAY_WIDTH-1:0] rx_cnt;
  logic [DELAY_WIDTH:0]   rx_cnt_inc;

  // One extra bit so the compare never wraps
  assign tx_cnt_inc = {1'b0, tx_cnt} + (DELAY_WIDTH+1)'(1);
  assign rx_cnt_inc = {1'b0, rx_cnt} + (DELAY_WIDTH+1)'(1);

  //////////////////////////////////////////////////
  // Transmit FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_nxt  = state;
    tx_cnt_nxt = tx_cnt;
    case (state)
      OFFLINE: begin
        // First cycle with tx_online high counts as one
        if (tx_online) begin
          tx_cnt_nxt = DELAY_WIDTH'(1);
          state_nxt  = (delay_y_value <= DELAY_WIDTH'(1)) ? ONLINE : WAIT_ON;
        end
      end
      WAIT_ON: begin
        if (!tx_online) begin
          state_nxt = OFFLINE;
        end else if (tx_cnt_inc >= {1'b0, delay_y_value}) begin
          state_nxt = ONLINE;
        end else begin
          tx_cnt_nxt = tx_cnt_inc[DELAY_WIDTH-1:0];
        end
      end
      ONLINE: begin
        if (!tx_online) begin
          tx_cnt_nxt = DELAY_WIDTH'(1);
          state_nxt  = (delay_z_value <= DELAY_WIDTH'(1)) ? OFFLINE : DRAIN;
        end
      end
      DRAIN: begin
        // Keep lanes alive until delay_z is used up
        if (tx_cnt_inc >= {1'b0, delay_z_value}) begin
          state_nxt = OFFLINE;
        end else begin
          tx_cnt_nxt = tx_cnt_inc[DELAY_WIDTH-1:0];
        end
      end
      default: state_nxt = OFFLINE;
    endcase
  end

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      state     <= OFFLINE;
      tx_cnt    <= '0;
      tx_active <= 1'b0;
    end else begin
      state     <= state_nxt;
      tx_cnt    <= tx_cnt_nxt;
      // Registered active flag for a clean output
      tx_active <= (state_nxt == ONLINE) || (state_nxt == DRAIN);
    end
  end

  // Persistent strobe and marker, decoded from FSM state
  assign tx_stb = (state == ONLINE) || (state == DRAIN);
  assign tx_mrk = tx_stb;

  //////////////////////////////////////////////////
  // Receive delay
  //////////////////////////////////////////////////

  always_ff @(posedge clk_wr) begin
    if (!rst_n || !rx_online) begin
      rx_active <= 1'b0;
      rx_cnt    <= '0;
    end else if (!rx_active) begin
      if (rx_cnt_inc >= {1'b0, delay_x_value}) begin
        rx_active <= 1'b1;
      end else begin
        rx_cnt <= rx_cnt_inc[DELAY_WIDTH-1:0];
      end
    end
  end

  // Strobe only while the registered flag agrees
  a_stb_needs_active: assert property (@(posedge clk_wr) disable iff (!rst_n)
    tx_stb |-> tx_active)
    else $error("tx_stb high while tx_active low");

  // Lanes only come up after tx_online was seen
  a_active_after_online: assert property (@(posedge clk_wr) disable iff (!rst_n)
    $rose(tx_active) |-> $past(tx_online))
    else $error("tx_active rose without tx_online");

endmodule

`default_nettype wire

// ==== verilog/lpif_pkg.sv ====
// Shared types and constants for the LPIF link shim
// Link word is 89 bits, packed with state in the MSBs and valid in bit 0
// Lanes 0 and 1 carry 39 word bits each, lane 2 carries the rest
// Bit 39 of lanes 0 and 1 is reserved for strobe and marker

`default_nettype none

package lpif_pkg;

  //////////////////////////////////////////////////
  // Link word fields
  //////////////////////////////////////////////////

  localparam int STATE_WIDTH  = 4;
  localparam int PROTID_WIDTH = 2;
  localparam int DATA_WIDTH   = 64;
  localparam int CRC_WIDTH    = 16;

  // One user transfer as it travels on the lanes
  // Field order sets the bit order on the wire
  typedef struct packed {
    logic [STATE_WIDTH-1:0]  state;
    logic [PROTID_WIDTH-1:0] protid;
    logic [DATA_WIDTH-1:0]   data;
    logic                    dvalid;
    logic [CRC_WIDTH-1:0]    crc;
    logic                    crc_valid;
    logic                    valid;
  } lpif_word_t;

  localparam int WORD_WIDTH = $bits(lpif_word_t);

  //////////////////////////////////////////////////
  // PHY lane layout
  //////////////////////////////////////////////////

  localparam int LANE_WIDTH = 40;

  // Strobe sits in lane 0, marker in lane 1
  localparam int STB_BIT = 39;
  localparam int MRK_BIT = 39;

  // Word bits carried by lanes 0 and 1
  localparam int LANE_PAYLOAD = 39;

  // Leftover word bits in lane 2
  localparam int LANE2_PAYLOAD = WORD_WIDTH - 2 * LANE_PAYLOAD;

  //////////////////////////////////////////////////
  // Auto-sync transmit FSM
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    OFFLINE,  // Lanes idle
    WAIT_ON,  // Counting delay_y after tx_online
    ONLINE,   // Strobe and marker driven
    DRAIN     // Counting delay_z after tx_online drops
  } sync_state_t;

endpackage

`default_nettype wire
